//--- Makefile
TOP = tb_cl_hello_world

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@if ! grep -q "Verification passed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- cl_hello_world.sv
`include "hello_params.svh"

module cl_hello_world (
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  input  ocl_bus_pkg::ocl_req_t ocl_req,
  output ocl_bus_pkg::ocl_rsp_t ocl_rsp,
  input  logic [`VLED_W-1:0]    sh_cl_status_vdip,
  output logic [`VLED_W-1:0]    cl_sh_status_vled
);
  import ocl_bus_pkg::*;
  import hello_reg_pkg::*;

  reg_wr_t                reg_wr;
  reg_rd_t                reg_rd;
  logic [`OCL_DATA_W-1:0] rd_data;
  cnt_cmd_t               cnt_cmd;
  logic [`CNT_W-1:0]      cnt_value;
  logic [`VLED_W-1:0]     hello_low;
  logic [`VLED_W-1:0]     vled_value;

  // AXI-Lite front end
  ocl_slave u_ocl_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req             (ocl_req),
    .rsp             (ocl_rsp),
    .reg_wr          (reg_wr),
    .reg_rd          (reg_rd),
    .rd_data         (rd_data)
  );

  // Register file and read mux
  hello_regs u_hello_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .reg_rd          (reg_rd),
    .rd_data         (rd_data),
    .cnt_cmd         (cnt_cmd),
    .cnt_value       (cnt_value),
    .vled_value      (vled_value),
    .hello_low       (hello_low)
  );

  tick_counter u_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cmd             (cnt_cmd),
    .value           (cnt_value)
  );

  // LED status path
  vled_out u_vled_out (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .hello_low       (hello_low),
    .vdip            (sh_cl_status_vdip),
    .vled            (cl_sh_status_vled),
    .vled_value      (vled_value)
  );

endmodule

//--- hello_cases.txt
# op      addr     data     expected   (all hex; wait: cycles in data, dip: switch word in data)
# ops: write read rdgt rdsame dip wait led
read   00000500 00000000 00000000
write  00000500 80001234 00000000
read   00000500 00000000 00002469
write  00000500 12345678 00000000
read   00000500 00000000 2468ACF0
read   00000510 00000000 DEADBEEF
read   00000000 00000000 DEADBEEF
dip    00000000 000000FF 00000000
write  00000500 A5A5C3C3 00000000
wait   00000000 00000005 00000000
read   00000504 00000000 0000C3C3
led    00000000 00000000 000000C3
read   00000500 00000000 4B4B8787
dip    00000000 0000F0F0 00000000
wait   00000000 00000004 00000000
led    00000000 00000000 0000C0C0
write  00000508 01000004 00000000
read   0000050C 00000000 00000100
read   00000508 00000000 01000000
write  00000508 01000001 00000000
wait   00000000 00000014 00000000
write  00000508 01000000 00000000
rdgt   0000050C 00000000 00000100
rdsame 0000050C 00000000 00000000
write  00000508 00000002 00000000
read   0000050C 00000000 00000000
write  00000508 FFF0000D 00000000
wait   00000000 00000028 00000000
read   0000050C 00000000 0000FFFF
read   00000508 00000000 FFF00009

//--- hello_params.svh
`ifndef HELLO_PARAMS_SVH
`define HELLO_PARAMS_SVH

// --------------------------------------
// Register map
// --------------------------------------
`define HELLO_REG_ADDR       32'h0000_0500
`define VLED_REG_ADDR        32'h0000_0504
`define CNT_CTRL_ADDR        32'h0000_0508
`define CNT_VALUE_ADDR       32'h0000_050C
// Returned for any address outside the map
`define UNIMPL_REG_VALUE     32'hDEAD_BEEF

// Bus and datapath widths
`define OCL_ADDR_W           32
`define OCL_DATA_W           32
`define VLED_W               16
`define CNT_W                16
`define TICK_W               8

// Reset values
`define HELLO_RESET_VALUE    32'h0000_0000
`define CNT_CTRL_RESET_VALUE 32'h0000_0000
`define CNT_RESET_VALUE      16'h0000
`define VLED_RESET_VALUE     16'h0000

`endif

//--- hello_reg_pkg.sv
`include "hello_params.svh"

package hello_reg_pkg;

  // --------------------------------------
  // Counter control word
  // --------------------------------------
  // Enable sits in bit 0, load value in the top half
  typedef struct packed {
    logic [`CNT_W-1:0]  load_value;
    logic [`TICK_W-1:0] tick_value;
    logic [3:0]         spare;
    logic               oneshot;
    logic               load;
    logic               clear;
    logic               enable;
  } cnt_ctrl_t;

  // Same bus word seen raw or as control fields
  typedef union packed {
    logic [`OCL_DATA_W-1:0] raw;
    cnt_ctrl_t              fields;
  } cnt_ctrl_u;

  // Command bundle to the counter
  // Clear and load arrive as single-cycle pulses
  typedef struct packed {
    logic               enable;
    logic               oneshot;
    logic               clear;
    logic               load;
    logic [`TICK_W-1:0] tick_value;
    logic [`CNT_W-1:0]  load_value;
  } cnt_cmd_t;

endpackage

//--- hello_regs.sv
`include "hello_params.svh"

module hello_regs (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  input  ocl_bus_pkg::reg_wr_t    reg_wr,
  input  ocl_bus_pkg::reg_rd_t    reg_rd,
  output logic [`OCL_DATA_W-1:0]  rd_data,
  output hello_reg_pkg::cnt_cmd_t cnt_cmd,
  input  logic [`CNT_W-1:0]       cnt_value,
  input  logic [`VLED_W-1:0]      vled_value,
  output logic [`VLED_W-1:0]      hello_low
);
  import hello_reg_pkg::*;

  cnt_ctrl_u              wr_word;
  logic [`OCL_DATA_W-1:0] hello_q;
  cnt_ctrl_t              ctrl_q;
  logic                   clear_pulse_q;
  logic                   load_pulse_q;
  logic                   hello_wr;
  logic                   ctrl_wr;
  logic [`OCL_DATA_W-1:0] hello_rot;
  logic [`OCL_DATA_W-1:0] rd_mux;

  // Incoming word, raw for hello and split for control
  always_comb begin
    wr_word.raw = reg_wr.data;
  end

  assign hello_wr = reg_wr.valid && (reg_wr.addr == `HELLO_REG_ADDR);
  assign ctrl_wr  = reg_wr.valid && (reg_wr.addr == `CNT_CTRL_ADDR);

  // --------------------------------------
  // Hello register
  // --------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q <= `HELLO_RESET_VALUE;
    end else if (hello_wr) begin
      hello_q <= wr_word.raw;
    end
  end

  // Read back rotated left by one
  assign hello_rot = {hello_q[`OCL_DATA_W-2:0], hello_q[`OCL_DATA_W-1]};
  // Low half feeds the LED shadow
  assign hello_low = hello_q[`VLED_W-1:0];

  // --------------------------------------
  // Counter control
  // --------------------------------------
  // Held fields, clear and load never stored
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ctrl_q <= `CNT_CTRL_RESET_VALUE;
    end else if (ctrl_wr) begin
      ctrl_q       <= wr_word.fields;
      ctrl_q.clear <= 1'b0;
      ctrl_q.load  <= 1'b0;
    end
  end

  // One-cycle pulses, seen by the counter the cycle after the write
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      clear_pulse_q <= 1'b0;
      load_pulse_q  <= 1'b0;
    end else begin
      clear_pulse_q <= ctrl_wr && wr_word.fields.clear;
      load_pulse_q  <= ctrl_wr && wr_word.fields.load;
    end
  end

  always_comb begin
    cnt_cmd.enable     = ctrl_q.enable;
    cnt_cmd.oneshot    = ctrl_q.oneshot;
    cnt_cmd.clear      = clear_pulse_q;
    cnt_cmd.load       = load_pulse_q;
    cnt_cmd.tick_value = ctrl_q.tick_value;
    cnt_cmd.load_value = ctrl_q.load_value;
  end

  // --------------------------------------
  // Read mux
  // --------------------------------------
  always_comb begin
    case (reg_rd.addr)
      `HELLO_REG_ADDR: rd_mux = hello_rot;
      `VLED_REG_ADDR:  rd_mux = {{(`OCL_DATA_W - `VLED_W){1'b0}}, vled_value};
      `CNT_CTRL_ADDR:  rd_mux = ctrl_q;
      `CNT_VALUE_ADDR: rd_mux = {{(`OCL_DATA_W - `CNT_W){1'b0}}, cnt_value};
      default:         rd_mux = `UNIMPL_REG_VALUE;
    endcase
  end

  // Zero outside the read strobe
  assign rd_data = reg_rd.valid ? rd_mux : '0;

  // Slave spaces writes, so pulses never run back to back
  a_pulse_single : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (cnt_cmd.clear || cnt_cmd.load) |=> !(cnt_cmd.clear || cnt_cmd.load))
    else $error("counter clear or load pulse longer than one cycle");

endmodule

//--- ocl_bus_pkg.sv
`include "hello_params.svh"

package ocl_bus_pkg;

  // AXI-Lite response code, only OKAY is ever returned
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // --------------------------------------
  // AXI-Lite channels
  // --------------------------------------
  // Host-driven side of the OCL port
  typedef struct packed {
    logic                     awvalid;
    logic [`OCL_ADDR_W-1:0]   awaddr;
    logic                     wvalid;
    logic [`OCL_DATA_W-1:0]   wdata;
    logic [`OCL_DATA_W/8-1:0] wstrb;
    logic                     bready;
    logic                     arvalid;
    logic [`OCL_ADDR_W-1:0]   araddr;
    logic                     rready;
  } ocl_req_t;

  // Slave-driven side
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [`OCL_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
  } ocl_rsp_t;

  // Internal register strobes, one cycle wide
  typedef struct packed {
    logic                   valid;
    logic [`OCL_ADDR_W-1:0] addr;
    logic [`OCL_DATA_W-1:0] data;
  } reg_wr_t;

  typedef struct packed {
    logic                   valid;
    logic [`OCL_ADDR_W-1:0] addr;
  } reg_rd_t;

endpackage

//--- ocl_slave.sv
`include "hello_params.svh"

module ocl_slave (
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n_sync,
  input  ocl_bus_pkg::ocl_req_t  req,
  output ocl_bus_pkg::ocl_rsp_t  rsp,
  output ocl_bus_pkg::reg_wr_t   reg_wr,
  output ocl_bus_pkg::reg_rd_t   reg_rd,
  input  logic [`OCL_DATA_W-1:0] rd_data
);
  import ocl_bus_pkg::*;

  // Write side
  logic                   wr_active_q;
  logic [`OCL_ADDR_W-1:0] wr_addr_q;
  logic                   bvalid_q;
  logic                   aw_fire;
  logic                   w_fire;
  logic                   b_fire;

  // Read side
  logic                   rd_pend_q;
  logic [`OCL_ADDR_W-1:0] rd_addr_q;
  logic                   rvalid_q;
  logic [`OCL_DATA_W-1:0] rdata_q;
  logic                   arready;
  logic                   ar_fire;
  logic                   r_fire;

  // --------------------------------------
  // Write address and data
  // --------------------------------------
  // Address taken only when nothing is pending
  assign aw_fire = req.awvalid && !wr_active_q;
  // One data beat per address, blocked once the response is up
  assign w_fire  = req.wvalid && wr_active_q && !bvalid_q;
  assign b_fire  = bvalid_q && req.bready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active_q <= 1'b0;
    end else if (b_fire) begin
      wr_active_q <= 1'b0;
    end else if (aw_fire) begin
      wr_active_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (aw_fire) begin
      wr_addr_q <= req.awaddr;
    end
  end

  // Response rises the edge after the data beat
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid_q <= 1'b0;
    end else if (b_fire) begin
      bvalid_q <= 1'b0;
    end else if (w_fire) begin
      bvalid_q <= 1'b1;
    end
  end

  // --------------------------------------
  // Read address and data
  // --------------------------------------
  // Single read in flight
  assign arready = !rd_pend_q && !rvalid_q;
  assign ar_fire = req.arvalid && arready;
  assign r_fire  = rvalid_q && req.rready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= ar_fire;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (ar_fire) begin
      rd_addr_q <= req.araddr;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid_q <= 1'b0;
    end else if (r_fire) begin
      rvalid_q <= 1'b0;
    end else if (rd_pend_q) begin
      rvalid_q <= 1'b1;
    end
  end

  // Data captured from the register mux, cleared once taken
  always_ff @(posedge clk_main_a0) begin
    if (rd_pend_q) begin
      rdata_q <= rd_data;
    end else if (r_fire) begin
      rdata_q <= '0;
    end
  end

  // Strobes toward the register stage
  always_comb begin
    reg_wr.valid = w_fire;
    reg_wr.addr  = wr_addr_q;
    reg_wr.data  = req.wdata;
    reg_rd.valid = rd_pend_q;
    reg_rd.addr  = rd_addr_q;
  end

  always_comb begin
    rsp.awready = !wr_active_q;
    rsp.wready  = w_fire;
    rsp.bvalid  = bvalid_q;
    rsp.bresp   = RESP_OKAY;
    rsp.arready = arready;
    rsp.rvalid  = rvalid_q;
    rsp.rdata   = rdata_q;
    rsp.rresp   = RESP_OKAY;
  end

  // --------------------------------------
  // Protocol checks
  // --------------------------------------
  // Responses wait for the host
  a_bvalid_hold : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rsp.bvalid && !req.bready |=> rsp.bvalid)
    else $error("bvalid dropped before bready");

  a_rvalid_hold : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata))
    else $error("rvalid or rdata changed before rready");

endmodule

//--- project.f
+incdir+.
ocl_bus_pkg.sv
hello_reg_pkg.sv
ocl_slave.sv
hello_regs.sv
tick_counter.sv
vled_out.sv
cl_hello_world.sv
tb_cl_hello_world.sv

//--- tb_cl_hello_world.sv
`include "hello_params.svh"

module tb_cl_hello_world;
  timeunit 1ns;
  timeprecision 100ps;
  import ocl_bus_pkg::*;

  logic                  clk_main_a0;
  logic                  rst_main_n_sync;
  ocl_req_t              req;
  ocl_rsp_t              rsp;
  logic [`VLED_W-1:0]    vdip;
  logic [`VLED_W-1:0]    vled;

  // Case table loaded from the data file
  string                  op_q[$];
  logic [`OCL_ADDR_W-1:0] addr_q[$];
  logic [`OCL_DATA_W-1:0] data_q[$];
  logic [`OCL_DATA_W-1:0] exp_q[$];

  integer                 seed = 32'h683e;
  int                     error_count;
  int                     check_count;
  int                     cycle_count;
  int                     limit_cycles;
  logic [`OCL_DATA_W-1:0] last_rd;

  cl_hello_world u_cl_hello_world (
    .clk_main_a0       (clk_main_a0),
    .rst_main_n_sync   (rst_main_n_sync),
    .ocl_req           (req),
    .ocl_rsp           (rsp),
    .sh_cl_status_vdip (vdip),
    .cl_sh_status_vled (vled)
  );

  // 10 ns clock
  initial begin
    clk_main_a0 = 1'b0;
    forever #5 clk_main_a0 = ~clk_main_a0;
  end

  // Watchdog, limit set once the cases are known
  initial begin
    cycle_count = 0;
    do begin
      @(posedge clk_main_a0);
      cycle_count++;
    end while (limit_cycles <= 0 || cycle_count <= limit_cycles);
    $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
    $display("Verification failed");
    $finish;
  end

  // --------------------------------------
  // Case file
  // --------------------------------------
  task automatic load_cases();
    int                     fd;
    int                     cnt;
    string                  line;
    string                  op;
    logic [`OCL_ADDR_W-1:0] a;
    logic [`OCL_DATA_W-1:0] d;
    logic [`OCL_DATA_W-1:0] e;
    fd = $fopen("hello_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open hello_cases.txt");
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      cnt = $fgets(line, fd);
      // Skip blank and comment lines
      if (cnt > 1 && line.getc(0) != "#") begin
        if ($sscanf(line, "%s %h %h %h", op, a, d, e) == 4) begin
          op_q.push_back(op);
          addr_q.push_back(a);
          data_q.push_back(d);
          exp_q.push_back(e);
        end else begin
          $display("Malformed line in hello_cases.txt: %s", line);
          error_count++;
        end
      end
    end
    $fclose(fd);
  endtask

  // --------------------------------------
  // AXI-Lite host tasks
  // --------------------------------------
  // Start and end 1 ns after a rising edge
  task automatic axi_write(input logic [`OCL_ADDR_W-1:0] addr,
                           input logic [`OCL_DATA_W-1:0] data);
    logic aw_done;
    logic w_done;
    logic aw_hit;
    logic w_hit;
    int   stall;
    aw_done     = 1'b0;
    w_done      = 1'b0;
    stall       = $unsigned($random(seed)) % 4;
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = '1;
    while (!(aw_done && w_done)) begin
      // Handshakes sampled mid-cycle, taken on the next edge
      @(negedge clk_main_a0);
      aw_hit = req.awvalid && rsp.awready;
      w_hit  = req.wvalid && rsp.wready;
      @(posedge clk_main_a0);
      #1;
      if (aw_hit) begin
        aw_done     = 1'b1;
        req.awvalid = 1'b0;
      end
      if (w_hit) begin
        w_done     = 1'b1;
        req.wvalid = 1'b0;
      end
    end
    // Response one edge after the data beat
    @(negedge clk_main_a0);
    if (!rsp.bvalid) begin
      $display("ERROR @%0t: bvalid late for write to 0x%08h", $time, addr);
      error_count++;
    end
    // Random bready stall
    repeat (stall) @(negedge clk_main_a0);
    @(posedge clk_main_a0);
    #1;
    req.bready = 1'b1;
    @(negedge clk_main_a0);
    while (!rsp.bvalid) @(negedge clk_main_a0);
    check_count++;
    if (rsp.bresp != 2'b00) begin
      $display("ERROR @%0t: bresp 0x%0h on write to 0x%08h", $time, rsp.bresp, addr);
      error_count++;
    end
    @(posedge clk_main_a0);
    #1;
    req.bready = 1'b0;
  endtask

  task automatic axi_read(input logic [`OCL_ADDR_W-1:0] addr,
                          output logic [`OCL_DATA_W-1:0] data);
    logic ar_hit;
    int   lat;
    int   stall;
    ar_hit      = 1'b0;
    stall       = $unsigned($random(seed)) % 4;
    req.arvalid = 1'b1;
    req.araddr  = addr;
    while (!ar_hit) begin
      @(negedge clk_main_a0);
      ar_hit = rsp.arready;
      @(posedge clk_main_a0);
      #1;
    end
    req.arvalid = 1'b0;
    // rvalid due two edges after the handshake edge
    lat = 1;
    @(negedge clk_main_a0);
    while (!rsp.rvalid) begin
      @(negedge clk_main_a0);
      lat++;
    end
    if (lat != 2) begin
      $display("ERROR @%0t: rvalid after %0d edges for 0x%08h", $time, lat, addr);
      error_count++;
    end
    // Random rready stall
    repeat (stall) @(negedge clk_main_a0);
    @(posedge clk_main_a0);
    #1;
    req.rready = 1'b1;
    @(negedge clk_main_a0);
    data = rsp.rdata;
    check_count++;
    if (rsp.rresp != 2'b00) begin
      $display("ERROR @%0t: rresp 0x%0h on read of 0x%08h", $time, rsp.rresp, addr);
      error_count++;
    end
    @(posedge clk_main_a0);
    #1;
    req.rready = 1'b0;
  endtask

  // --------------------------------------
  // One case from the table
  // --------------------------------------
  task automatic run_case(input int idx);
    string                  op;
    logic [`OCL_ADDR_W-1:0] addr;
    logic [`OCL_DATA_W-1:0] data;
    logic [`OCL_DATA_W-1:0] expv;
    logic [`OCL_DATA_W-1:0] rd_val;
    op   = op_q[idx];
    addr = addr_q[idx];
    data = data_q[idx];
    expv = exp_q[idx];
    case (op)
      "write": axi_write(addr, data);
      "read": begin
        axi_read(addr, rd_val);
        if (rd_val != expv) begin
          $display("ERROR @%0t: read 0x%08h got 0x%08h expected 0x%08h",
                   $time, addr, rd_val, expv);
          error_count++;
        end
        last_rd = rd_val;
      end
      // Counter has moved past a bound
      "rdgt": begin
        axi_read(addr, rd_val);
        if (rd_val <= expv) begin
          $display("ERROR @%0t: read 0x%08h got 0x%08h, not above 0x%08h",
                   $time, addr, rd_val, expv);
          error_count++;
        end
        last_rd = rd_val;
      end
      // Same as the previous read
      "rdsame": begin
        axi_read(addr, rd_val);
        if (rd_val != last_rd) begin
          $display("ERROR @%0t: read 0x%08h got 0x%08h, previous 0x%08h",
                   $time, addr, rd_val, last_rd);
          error_count++;
        end
        last_rd = rd_val;
      end
      "dip": vdip = data[`VLED_W-1:0];
      "wait": begin
        repeat (data) @(posedge clk_main_a0);
        #1;
      end
      "led": begin
        check_count++;
        if (vled != expv[`VLED_W-1:0]) begin
          $display("ERROR @%0t: LED output 0x%04h expected 0x%04h",
                   $time, vled, expv[`VLED_W-1:0]);
          error_count++;
        end
      end
      default: begin
        $display("Unknown operation '%s' in case %0d", op, idx);
        error_count++;
      end
    endcase
  endtask

  // --------------------------------------
  // Main sequence
  // --------------------------------------
  initial begin
    req             = '0;
    vdip            = '0;
    rst_main_n_sync = 1'b0;
    error_count     = 0;
    check_count     = 0;
    limit_cycles    = 0;
    last_rd         = '0;
    load_cases();
    if (op_q.size() == 0) begin
      $display("No test cases were loaded");
      error_count++;
    end
    limit_cycles = op_q.size() * 200 + 100;
    // Reset held for 4 cycles
    repeat (4) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;
    for (int i = 0; i < op_q.size(); i++) begin
      run_case(i);
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- tick_counter.sv
`include "hello_params.svh"

module tick_counter (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  input  hello_reg_pkg::cnt_cmd_t cmd,
  output logic [`CNT_W-1:0]       value
);

  logic [`TICK_W-1:0] tick_cnt_q;
  logic [`CNT_W-1:0]  cnt_q;
  logic               tick;
  logic               at_max;

  // --------------------------------------
  // Prescaler
  // --------------------------------------
  // Tick when the count reaches tick_value, zero gives a tick per cycle
  assign tick = (tick_cnt_q >= cmd.tick_value);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_cnt_q <= '0;
    end else if (cmd.clear) begin
      tick_cnt_q <= '0;
    end else if (cmd.enable) begin
      // Wrap on tick
      tick_cnt_q <= tick ? '0 : tick_cnt_q + 1'b1;
    end
  end

  // --------------------------------------
  // Event counter
  // --------------------------------------
  assign at_max = (cnt_q == {`CNT_W{1'b1}});

  // Clear over load over counting
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cnt_q <= `CNT_RESET_VALUE;
    end else if (cmd.clear) begin
      cnt_q <= '0;
    end else if (cmd.load) begin
      cnt_q <= cmd.load_value;
    end else if (cmd.enable && tick && !(cmd.oneshot && at_max)) begin
      // Oneshot parks at all ones
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign value = cnt_q;

  // Saturation holds across the edge
  a_oneshot_sat : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    cmd.oneshot && at_max && !cmd.clear && !cmd.load |=> cnt_q != '0)
    else $error("oneshot counter wrapped");

endmodule

//--- vled_out.sv
`include "hello_params.svh"

module vled_out (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic [`VLED_W-1:0] hello_low,
  input  logic [`VLED_W-1:0] vdip,
  output logic [`VLED_W-1:0] vled,
  output logic [`VLED_W-1:0] vled_value
);

  logic [`VLED_W-1:0] shadow_q;
  logic [`VLED_W-1:0] dip_meta_q;
  logic [`VLED_W-1:0] dip_sync_q;
  logic [`VLED_W-1:0] vled_q;

  // Shadow of the hello low half
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      shadow_q <= `VLED_RESET_VALUE;
    end else begin
      shadow_q <= hello_low;
    end
  end

  // Two-flop synchronizer for the DIP switches
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      dip_meta_q <= '0;
      dip_sync_q <= '0;
    end else begin
      dip_meta_q <= vdip;
      dip_sync_q <= dip_meta_q;
    end
  end

  // Masked LED word, registered to the pins
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q <= `VLED_RESET_VALUE;
    end else begin
      vled_q <= shadow_q & dip_sync_q;
    end
  end

  assign vled       = vled_q;
  // Unmasked for readback
  assign vled_value = shadow_q;

endmodule
